//--- vid_pkg.sv
// shared constants for the monochrome video controller
// pixel word size, the two output colours and the horizontal phase states
`default_nettype none

package vid_pkg;

  // ------------------------------
  // frame buffer word
  // ------------------------------

  // pixels held in one memory word, also the serializer length
  localparam int PIX_PER_WORD = 32;

  // host data and memory word width
  localparam int WORD_W = PIX_PER_WORD;

  // ------------------------------
  // colours
  // ------------------------------

  // lit pixel, shown for a 0 bit
  localparam logic [7:0] FG_R = 8'h7C;
  localparam logic [7:0] FG_G = 8'hD4;
  localparam logic [7:0] FG_B = 8'hD6;

  // dark pixel, shown for a 1 bit
  localparam logic [7:0] BG_R = 8'h00;
  localparam logic [7:0] BG_G = 8'h00;
  localparam logic [7:0] BG_B = 8'h00;

  // ------------------------------
  // line phases
  // ------------------------------

  // order follows the sweep along one line
  typedef enum logic [1:0] {
    h_active = 2'd0,
    h_front  = 2'd1,
    h_sync   = 2'd2,
    h_back   = 2'd3
  } h_phase_e;

endpackage

`default_nettype wire

//--- vid_timing.sv
// raster timing generator, sweeps the screen and addresses the frame buffer
// all outputs describe the current counter position, downstream adds latency
`timescale 1ns/1ps
`default_nettype none

module vid_timing #(
  parameter int H_ACTIVE = 1024,
  parameter int H_FRONT  = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BACK   = 144,
  parameter int V_ACTIVE = 768,
  parameter int V_FRONT  = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BACK   = 29
) (
  input  logic pclk,
  input  logic rst,
  output logic [$clog2(V_ACTIVE)+$clog2(H_ACTIVE/vid_pkg::PIX_PER_WORD)-1:0] rd_addr,
  output logic [$clog2(vid_pkg::PIX_PER_WORD)-1:0] pix_idx,
  output logic blank,
  output logic hs,
  output logic vs
);
  import vid_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HC_W    = $clog2(H_TOTAL);
  localparam int VC_W    = $clog2(V_TOTAL);
  localparam int PIX_W   = $clog2(PIX_PER_WORD);
  localparam int WRD_W   = $clog2(H_ACTIVE / PIX_PER_WORD);
  localparam int ROW_W   = $clog2(V_ACTIVE);

  // last count of each horizontal phase
  localparam logic [HC_W-1:0] H_ACT_END  = HC_W'(H_ACTIVE - 1);
  localparam logic [HC_W-1:0] H_FP_END   = HC_W'(H_ACTIVE + H_FRONT - 1);
  localparam logic [HC_W-1:0] H_SYNC_END = HC_W'(H_ACTIVE + H_FRONT + H_SYNC - 1);
  localparam logic [HC_W-1:0] H_LINE_END = HC_W'(H_TOTAL - 1);

  // vertical marks, in lines
  localparam logic [VC_W-1:0] V_ACT_END   = VC_W'(V_ACTIVE - 1);
  localparam logic [VC_W-1:0] V_SYNC_ON   = VC_W'(V_ACTIVE + V_FRONT);
  localparam logic [VC_W-1:0] V_SYNC_OFF  = VC_W'(V_ACTIVE + V_FRONT + V_SYNC);
  localparam logic [VC_W-1:0] V_FRAME_END = VC_W'(V_TOTAL - 1);

  h_phase_e        h_phase;
  logic [HC_W-1:0] hcnt;
  logic [VC_W-1:0] vcnt;
  logic            vblank;
  logic            vsync_on;
  logic            line_end;
  logic            sync_start;

  assign line_end   = (hcnt == H_LINE_END);
  // hsync begins on the next count, vsync toggles at the same point
  assign sync_start = (hcnt == H_FP_END);

  // ------------------------------
  // horizontal sweep
  // ------------------------------

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcnt    <= '0;
      h_phase <= h_active;
    end else begin
      if (line_end) begin
        hcnt <= '0;
      end else begin
        hcnt <= hcnt + 1'b1;
      end
      case (h_phase)
        h_active: if (hcnt == H_ACT_END) h_phase <= h_front;
        h_front:  if (sync_start) h_phase <= h_sync;
        h_sync:   if (hcnt == H_SYNC_END) h_phase <= h_back;
        h_back:   if (line_end) h_phase <= h_active;
        default:  h_phase <= h_active;
      endcase
    end
  end

  // ------------------------------
  // vertical sweep
  // ------------------------------

  always_ff @(posedge pclk) begin
    if (rst) begin
      vcnt     <= '0;
      vblank   <= 1'b0;
      vsync_on <= 1'b0;
    end else begin
      if (line_end) begin
        if (vcnt == V_FRAME_END) begin
          vcnt   <= '0;
          vblank <= 1'b0;
        end else begin
          vcnt <= vcnt + 1'b1;
        end
        if (vcnt == V_ACT_END) begin
          vblank <= 1'b1;
        end
      end
      if (sync_start) begin
        if (vcnt == V_SYNC_ON) begin
          vsync_on <= 1'b1;
        end else if (vcnt == V_SYNC_OFF) begin
          vsync_on <= 1'b0;
        end
      end
    end
  end

  assign blank   = (h_phase != h_active) | vblank;
  assign hs      = (h_phase == h_sync);
  assign vs      = vsync_on;
  assign pix_idx = hcnt[PIX_W-1:0];

  // row above word index, outside the active area the value is don't care
  assign rd_addr = {vcnt[ROW_W-1:0], hcnt[PIX_W +: WRD_W]};

endmodule

`default_nettype wire

//--- vid_mem.sv
// frame buffer, host write port with mirrored rows and a registered video read
// host rows at or above V_ACTIVE are dropped
`timescale 1ns/1ps
`default_nettype none

module vid_mem #(
  parameter int H_ACTIVE = 1024,
  parameter int V_ACTIVE = 768
) (
  input  logic pclk,
  input  logic en,
  input  logic wr,
  input  logic [$clog2(V_ACTIVE+1)+$clog2(H_ACTIVE/vid_pkg::PIX_PER_WORD)-1:0] adr,
  input  logic [vid_pkg::WORD_W-1:0] din,
  input  logic [$clog2(V_ACTIVE)+$clog2(H_ACTIVE/vid_pkg::PIX_PER_WORD)-1:0] rd_addr,
  output logic [vid_pkg::WORD_W-1:0] rd_data
);
  import vid_pkg::*;

  localparam int WORDS  = H_ACTIVE / PIX_PER_WORD;
  localparam int WRD_W  = $clog2(WORDS);
  localparam int HROW_W = $clog2(V_ACTIVE + 1);
  localparam int ROW_W  = $clog2(V_ACTIVE);
  localparam int DEPTH  = V_ACTIVE * WORDS;

  localparam logic [HROW_W-1:0] LAST_ROW = HROW_W'(V_ACTIVE - 1);

  logic [WORD_W-1:0]      mem [0:DEPTH-1];
  logic [HROW_W-1:0]      host_row;
  logic [WRD_W-1:0]       host_word;
  logic [HROW_W-1:0]      flip_row;
  logic                   row_ok;
  logic [ROW_W+WRD_W-1:0] wr_addr;

  // ------------------------------
  // host side
  // ------------------------------

  assign host_row  = adr[WRD_W +: HROW_W];
  assign host_word = adr[WRD_W-1:0];
  assign row_ok    = (host_row <= LAST_ROW);

  // host row 0 lands on the bottom display line
  assign flip_row = LAST_ROW - host_row;
  assign wr_addr  = {flip_row[ROW_W-1:0], host_word};

  always_ff @(posedge pclk) begin
    if (en && wr && row_ok) begin
      mem[wr_addr] <= din;
    end
  end

  // ------------------------------
  // video side
  // ------------------------------

  // a same-cycle write is seen on the next read
  always_ff @(posedge pclk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- vid_pixel.sv
// pixel serializer, aligns control with the memory read and shifts the word out
// bit 0 of each word is the leftmost pixel, syncs leave through one more register
`timescale 1ns/1ps
`default_nettype none

module vid_pixel (
  input  logic pclk,
  input  logic rst,
  input  logic [vid_pkg::WORD_W-1:0] rd_data,
  input  logic [$clog2(vid_pkg::PIX_PER_WORD)-1:0] pix_idx,
  input  logic blank,
  input  logic hs,
  input  logic vs,
  output logic hsync,
  output logic vsync,
  output logic blank_n,
  output logic [7:0] r,
  output logic [7:0] g,
  output logic [7:0] b
);
  import vid_pkg::*;

  localparam int PIX_W = $clog2(PIX_PER_WORD);

  logic [PIX_W-1:0]        pix_idx_d;
  logic                    blank_d;
  logic                    hs_d;
  logic                    vs_d;
  logic [PIX_PER_WORD-1:0] shift_q;
  logic                    blank_q;
  logic                    hs_q;
  logic                    vs_q;
  logic                    lit;

  // ------------------------------
  // stage 1, match the read
  // ------------------------------

  always_ff @(posedge pclk) begin
    if (rst) begin
      pix_idx_d <= '0;
      blank_d   <= 1'b1;
      hs_d      <= 1'b0;
      vs_d      <= 1'b0;
    end else begin
      pix_idx_d <= pix_idx;
      blank_d   <= blank;
      hs_d      <= hs;
      vs_d      <= vs;
    end
  end

  // ------------------------------
  // stage 2, shift register
  // ------------------------------

  always_ff @(posedge pclk) begin
    if (pix_idx_d == '0) begin
      shift_q <= rd_data;
    end else begin
      shift_q <= {1'b0, shift_q[PIX_PER_WORD-1:1]};
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      blank_q <= 1'b1;
      hs_q    <= 1'b0;
      vs_q    <= 1'b0;
    end else begin
      blank_q <= blank_d;
      hs_q    <= hs_d;
      vs_q    <= vs_d;
    end
  end

  // syncs are active low at the connector
  always_ff @(posedge pclk) begin
    if (rst) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      hsync <= ~hs_q;
      vsync <= ~vs_q;
    end
  end

  // a clear bit lights the pixel
  assign lit     = ~shift_q[0];
  assign blank_n = ~blank_q;

  assign r = !blank_n ? 8'h00 : (lit ? FG_R : BG_R);
  assign g = !blank_n ? 8'h00 : (lit ? FG_G : BG_G);
  assign b = !blank_n ? 8'h00 : (lit ? FG_B : BG_B);

endmodule

`default_nettype wire

//--- vid_top.sv
// video controller top, host strobe writes in and raster video out
// geometry parameters default to 1024x768 and are handed to the blocks below
`timescale 1ns/1ps
`default_nettype none

module vid_top #(
  parameter int H_ACTIVE = 1024,
  parameter int H_FRONT  = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BACK   = 144,
  parameter int V_ACTIVE = 768,
  parameter int V_FRONT  = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BACK   = 29
) (
  input  logic pclk,
  input  logic rst,
  input  logic en,
  input  logic wr,
  input  logic [$clog2(V_ACTIVE+1)+$clog2(H_ACTIVE/vid_pkg::PIX_PER_WORD)-1:0] adr,
  input  logic [vid_pkg::WORD_W-1:0] din,
  output logic hsync,
  output logic vsync,
  output logic blank_n,
  output logic [7:0] r,
  output logic [7:0] g,
  output logic [7:0] b
);
  import vid_pkg::*;

  // frame buffer read address, row above word
  localparam int RA_W  = $clog2(V_ACTIVE) + $clog2(H_ACTIVE / PIX_PER_WORD);
  localparam int PIX_W = $clog2(PIX_PER_WORD);

  logic [RA_W-1:0]   rd_addr;
  logic [PIX_W-1:0]  pix_idx;
  logic              blank;
  logic              hs;
  logic              vs;
  logic [WORD_W-1:0] rd_data;

  vid_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_timing (
    .pclk    (pclk),
    .rst     (rst),
    .rd_addr (rd_addr),
    .pix_idx (pix_idx),
    .blank   (blank),
    .hs      (hs),
    .vs      (vs)
  );

  vid_mem #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_mem (
    .pclk    (pclk),
    .en      (en),
    .wr      (wr),
    .adr     (adr),
    .din     (din),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  vid_pixel u_pixel (
    .pclk    (pclk),
    .rst     (rst),
    .rd_data (rd_data),
    .pix_idx (pix_idx),
    .blank   (blank),
    .hs      (hs),
    .vs      (vs),
    .hsync   (hsync),
    .vsync   (vsync),
    .blank_n (blank_n),
    .r       (r),
    .g       (g),
    .b       (b)
  );

endmodule

`default_nettype wire

//--- tb_vid_check.sv
// testbench checker that keeps a frame buffer model built from the host strobes
// and compares blanking, syncs and pixels on the falling clock edge
`timescale 1ns/1ps
`default_nettype none

module tb_vid_check #(
  parameter int H_ACTIVE = 1024,
  parameter int H_FRONT  = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BACK   = 144,
  parameter int V_ACTIVE = 768,
  parameter int V_FRONT  = 3,
  parameter int V_SYNC   = 6
) (
  input  logic pclk, rst, en, wr,
  input  logic [$clog2(V_ACTIVE+1)+$clog2(H_ACTIVE/vid_pkg::PIX_PER_WORD)-1:0] adr,
  input  logic [vid_pkg::WORD_W-1:0] din,
  input  logic hsync, vsync, blank_n,
  input  logic [7:0] r, g, b,
  output int errors, clean_frames, pixels_checked
);
  import vid_pkg::*;

  localparam int WORDS   = H_ACTIVE / PIX_PER_WORD;
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  // from the last blank_n fall of a frame to the vsync fall
  localparam int VS_LEAD = (V_FRONT + 1) * H_TOTAL + H_FRONT + 1;

  logic [WORD_W-1:0] model [V_ACTIVE][WORDS];
  bit                known [V_ACTIVE][WORDS];
  h_phase_e          phase;
  bit                in_reset, seen_active, frame_open;
  bit                prev_blank, prev_hs, prev_vs;
  int                strobes, strobe_mark, cyc, x, lines, run;
  int                t_bfall, t_hfall, t_vfall;

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic expect_gap(input string what, input int got, input int want);
    if (got != want) begin
      report_mismatch($sformatf("%s is %0d cycles, expected %0d", what, got, want));
    end
  endtask

  // ------------------------------
  // host strobes into the model
  // ------------------------------
  always @(posedge pclk) begin
    int hrow;
    int word;
    hrow = int'(adr) / WORDS;
    word = int'(adr) % WORDS;
    in_reset = rst;
    if (rst) begin
      strobes = 0;
      foreach (known[i, j]) known[i][j] = 1'b0;
    end else if (en && wr) begin
      strobes++;
      // host row 0 is the bottom line and rows past the screen are lost
      if (hrow < V_ACTIVE) begin
        model[V_ACTIVE-1-hrow][word] = din;
        known[V_ACTIVE-1-hrow][word] = 1'b1;
      end
    end
  end

  // ------------------------------
  // raster model
  // ------------------------------
  always @(negedge pclk) begin
    logic        pix_bit;
    logic [23:0] want_rgb;
    if (in_reset) begin
      // outputs hold their reset state while rst is high
      if (blank_n !== 1'b0 || {r, g, b} !== 24'h0 || hsync !== 1'b1 || vsync !== 1'b1) begin
        report_mismatch($sformatf("reset state blank_n %b hsync %b vsync %b colour %06h",
                                  blank_n, hsync, vsync, {r, g, b}));
      end
      clean_frames = 0;
      pixels_checked = 0;
      seen_active = 0;
      frame_open = 0;
      prev_blank = 0;
      prev_hs = 1;
      prev_vs = 1;
      phase = h_back;
      cyc = 0;
      lines = 0;
      run = 0;
      x = 0;
      t_bfall = -1;
      t_hfall = -1;
      t_vfall = -1;
      strobe_mark = 0;
    end else begin
      cyc++;
      if (!seen_active && !blank_n && (!hsync || !vsync)) begin
        report_mismatch("sync active before the first active line");
      end
      if (!blank_n && {r, g, b} != 24'h0) begin
        report_mismatch($sformatf("colour %06h while blanked", {r, g, b}));
      end
      if (blank_n && !prev_blank) begin
        seen_active = 1;
        phase = h_active;
        lines++;
        x = 0;
        run = 0;
      end
      if (blank_n) begin
        run++;
        // only frames without a strobe since the last vsync fall
        if (frame_open && strobes == strobe_mark && lines >= 1 && lines <= V_ACTIVE &&
            x < H_ACTIVE && known[lines-1][x / PIX_PER_WORD]) begin
          pix_bit  = model[lines-1][x / PIX_PER_WORD][x % PIX_PER_WORD];
          want_rgb = pix_bit ? 24'h000000 : 24'h7CD4D6;
          pixels_checked++;
          if ({r, g, b} != want_rgb) begin
            report_mismatch($sformatf("line %0d col %0d expected %06h got %06h",
                                      lines - 1, x, want_rgb, {r, g, b}));
          end
        end
        x++;
      end
      if (!blank_n && prev_blank) begin
        expect_gap("active video", run, H_ACTIVE);
        phase = h_front;
        t_bfall = cyc;
      end
      if (!hsync && prev_hs) begin
        if (phase == h_active) report_mismatch("hsync fell during active video");
        if (phase == h_front) expect_gap("front porch", cyc - t_bfall, H_FRONT + 1);
        if (t_hfall >= 0) expect_gap("line period", cyc - t_hfall, H_TOTAL);
        phase = h_sync;
        t_hfall = cyc;
      end
      if (hsync && !prev_hs) begin
        expect_gap("hsync pulse", cyc - t_hfall, H_SYNC);
        phase = h_back;
      end
      if (!vsync && prev_vs) begin
        if (t_bfall >= 0) expect_gap("vsync lead", cyc - t_bfall, VS_LEAD);
        if (frame_open) expect_gap("active line count", lines, V_ACTIVE);
        if (frame_open && strobes == strobe_mark) clean_frames++;
        frame_open = 1;
        strobe_mark = strobes;
        lines = 0;
        t_vfall = cyc;
      end
      if (vsync && !prev_vs) begin
        expect_gap("vsync pulse", cyc - t_vfall, V_SYNC * H_TOTAL);
      end
      prev_blank = blank_n;
      prev_hs = hsync;
      prev_vs = vsync;
    end
  end

endmodule

`default_nettype wire

//--- tb_vid.sv
// testbench top for the video controller on a small screen
// writes a table of words, then an LCG fill, and waits for clean checked frames
`timescale 1ns/1ps
`default_nettype none

module tb_vid;
  import vid_pkg::*;

  localparam int H_ACTIVE = 64;
  localparam int H_FRONT  = 8;
  localparam int H_SYNC   = 16;
  localparam int H_BACK   = 8;
  localparam int V_ACTIVE = 8;
  localparam int V_FRONT  = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 3;
  localparam int WORDS    = H_ACTIVE / PIX_PER_WORD;
  localparam int ADR_W    = $clog2(V_ACTIVE + 1) + $clog2(WORDS);
  localparam int FRAME    = 96 * 15;
  localparam int N_STIM   = 10;

  // host row, word in row, data
  localparam logic [36:0] STIM [N_STIM] = '{
    {4'd0,  1'b0, 32'hFFFF_FFFF},
    {4'd0,  1'b1, 32'h0000_0000},
    {4'd7,  1'b0, 32'h0000_0001},
    {4'd7,  1'b1, 32'h8000_0000},
    {4'd3,  1'b0, 32'hA5A5_0FF0},
    {4'd4,  1'b1, 32'h0000_FFFF},
    // these two alias rows 0 and 7 in their low bits
    {4'd8,  1'b0, 32'h1234_5678},
    {4'd15, 1'b1, 32'hDEAD_BEEF},
    {4'd8,  1'b1, 32'h5555_AAAA},
    {4'd15, 1'b0, 32'h0F0F_F0F0}
  };

  logic              pclk, rst, en, wr;
  logic [ADR_W-1:0]  adr;
  logic [WORD_W-1:0] din;
  logic              hsync, vsync, blank_n;
  logic [7:0]        r, g, b;
  int                errors, clean_frames, pixels_checked;
  int                fails;
  logic [31:0]       lcg_state;

  vid_top #(
    .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
    .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
  ) u_vid_top (
    .pclk (pclk), .rst (rst), .en (en), .wr (wr), .adr (adr), .din (din),
    .hsync (hsync), .vsync (vsync), .blank_n (blank_n), .r (r), .g (g), .b (b)
  );

  tb_vid_check #(
    .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
    .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC)
  ) u_check (
    .pclk (pclk), .rst (rst), .en (en), .wr (wr), .adr (adr), .din (din),
    .hsync (hsync), .vsync (vsync), .blank_n (blank_n), .r (r), .g (g), .b (b),
    .errors (errors), .clean_frames (clean_frames), .pixels_checked (pixels_checked)
  );

  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // one-cycle strobe, driven on the falling edge
  task automatic write_word(input int row, input int word, input logic [31:0] data);
    @(negedge pclk);
    en  = 1'b1;
    wr  = 1'b1;
    adr = ADR_W'(row * WORDS + word);
    din = data;
    @(negedge pclk);
    en  = 1'b0;
    wr  = 1'b0;
  endtask

  task automatic wait_clean_frames(input int count, input string step);
    int   target;
    int   edges;
    int   cycles;
    logic prev_vsync;
    target = clean_frames + count;
    edges = 0;
    cycles = 0;
    prev_vsync = vsync;
    while (clean_frames < target && edges <= count + 2 && cycles < (count + 3) * FRAME) begin
      @(posedge pclk);
      cycles++;
      if (prev_vsync && !vsync) edges++;
      prev_vsync = vsync;
    end
    if (clean_frames < target) begin
      fails++;
      $display("Timeout: %s did not reach %0d clean frames after %0d vsync edges",
               step, count, edges);
    end
  endtask

  initial begin
    logic [36:0] entry;
    rst = 1'b1;
    en = 1'b0;
    wr = 1'b0;
    adr = '0;
    din = '0;
    fails = 0;
    lcg_state = 32'd41;
    repeat (8) @(negedge pclk);
    rst = 1'b0;

    for (int i = 0; i < N_STIM; i++) begin
      entry = STIM[i];
      write_word(int'(entry[36:33]), int'(entry[32]), entry[31:0]);
    end
    wait_clean_frames(2, "stimulus table");

    for (int row = 0; row < V_ACTIVE; row++) begin
      for (int w = 0; w < WORDS; w++) begin
        write_word(row, w, lcg_next());
      end
    end
    wait_clean_frames(2, "random fill");

    if (pixels_checked == 0) begin
      fails++;
      $display("No pixel was compared during the run");
    end
    $display("mismatches %0d, other failures %0d, pixels compared %0d",
             errors, fails, pixels_checked);
    if (errors == 0 && fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
vid_pkg.sv
vid_timing.sv
vid_mem.sv
vid_pixel.sv
vid_top.sv
tb_vid_check.sv
tb_vid.sv

//--- run.sh
#!/bin/sh
# builds the video controller testbench with Verilator, runs it and checks the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_vid \
  > build.log 2>&1 &&
./obj_dir/Vtb_vid > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
